// ==== rtl/lpif_pkg.sv ====
/* LPIF link shared definitions
   Flit layout, lane geometry and auto-sync states */

package lpif_pkg;

  ////////////////////////////////////////////////////////////
  // Lane geometry

  // PHY channel count
  localparam int NUM_LANES      = 4;
  // Raw PHY word per channel
  localparam int LANE_W         = 40;
  // Bits 38..1 carry payload, bit 0 strobe, bit 39 marker
  localparam int LANE_PAYLOAD_W = 38;
  // Strobe and marker positions inside a lane word
  localparam int LANE_STB_BIT   = 0;
  localparam int LANE_MRK_BIT   = 39;

  // Flit width, all user fields packed
  localparam int FLIT_W         = 141;
  // Flit zero-extended to fill every lane payload
  localparam int LANE_PAD_W     = NUM_LANES * LANE_PAYLOAD_W;

  // Debug counter width, two counters per status word
  localparam int DBG_CNT_W      = 16;

  ////////////////////////////////////////////////////////////
  // Flit word

  // Field order sets bit position in the lanes
  // Valid sits at bit 0, state at the top
  typedef struct packed {
    logic [3:0]   state;
    logic [1:0]   protid;
    logic [127:0] data;
    logic         dvalid;
    logic [3:0]   crc;
    logic         crc_valid;
    logic         valid;
  } lpif_flit_t;

  ////////////////////////////////////////////////////////////
  // Auto-sync FSM

  // Tx uses all four states
  // Rx skips SYNC_WAIT_Z
  typedef enum logic [1:0] {
    SYNC_IDLE   = 2'd0,
    SYNC_WAIT_Y = 2'd1,
    SYNC_WAIT_Z = 2'd2,
    SYNC_ONLINE = 2'd3
  } sync_state_e;

endpackage

// ==== rtl/link_auto_sync.sv ====
/* Link auto-sync, delays tx/rx online levels by programmable counts
   and opens the persistent strobe ahead of payload */

`timescale 1ns/100ps

module link_auto_sync #(
  parameter int DELAY_W = 16
) (
  input  logic               clk_wr,
  input  logic               rst,

  // Raw online levels
  input  logic               tx_online,
  input  logic               rx_online,

  // Programmable delays
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,
  input  logic [DELAY_W-1:0] delay_z_value,

  // Delayed levels to the lane block
  output logic               tx_online_delay,
  output logic               tx_strobe_en,
  output logic               rx_online_delay
);

  lpif_pkg::sync_state_e tx_state;
  lpif_pkg::sync_state_e rx_state;
  logic [DELAY_W-1:0]    tx_cnt;
  logic [DELAY_W-1:0]    rx_cnt;
  logic                  tx_cnt_last;
  logic                  rx_cnt_last;

  // Count of 0 or 1 ends the wait
  // so a zero delay still spends one cycle in its state
  assign tx_cnt_last = (tx_cnt[DELAY_W-1:1] == '0);
  assign rx_cnt_last = (rx_cnt[DELAY_W-1:1] == '0);

  ////////////////////////////////////////////////////////////
  // Tx side, strobe-only words then payload

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_state <= lpif_pkg::SYNC_IDLE;
      tx_cnt   <= '0;
    end else if (!tx_online) begin
      // Link dropped, restart bring-up
      tx_state <= lpif_pkg::SYNC_IDLE;
      tx_cnt   <= '0;
    end else begin
      case (tx_state)
        lpif_pkg::SYNC_IDLE: begin
          tx_state <= lpif_pkg::SYNC_WAIT_Y;
          tx_cnt   <= delay_y_value;
        end
        lpif_pkg::SYNC_WAIT_Y: begin
          if (tx_cnt_last) begin
            tx_state <= lpif_pkg::SYNC_WAIT_Z;
            tx_cnt   <= delay_z_value;
          end else begin
            tx_cnt <= tx_cnt - 1'b1;
          end
        end
        lpif_pkg::SYNC_WAIT_Z: begin
          // Strobe running, payload still held off
          if (tx_cnt_last) begin
            tx_state <= lpif_pkg::SYNC_ONLINE;
          end else begin
            tx_cnt <= tx_cnt - 1'b1;
          end
        end
        default: begin
          tx_state <= lpif_pkg::SYNC_ONLINE;
        end
      endcase
    end
  end

  assign tx_strobe_en    = (tx_state == lpif_pkg::SYNC_WAIT_Z) ||
                           (tx_state == lpif_pkg::SYNC_ONLINE);
  assign tx_online_delay = (tx_state == lpif_pkg::SYNC_ONLINE);

  ////////////////////////////////////////////////////////////
  // Rx side, single wait reusing SYNC_WAIT_Y

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_state <= lpif_pkg::SYNC_IDLE;
      rx_cnt   <= '0;
    end else if (!rx_online) begin
      rx_state <= lpif_pkg::SYNC_IDLE;
      rx_cnt   <= '0;
    end else begin
      case (rx_state)
        lpif_pkg::SYNC_IDLE: begin
          rx_state <= lpif_pkg::SYNC_WAIT_Y;
          rx_cnt   <= delay_x_value;
        end
        lpif_pkg::SYNC_WAIT_Y: begin
          if (rx_cnt_last) begin
            rx_state <= lpif_pkg::SYNC_ONLINE;
          end else begin
            rx_cnt <= rx_cnt - 1'b1;
          end
        end
        default: begin
          // Online holds until rx_online drops
          rx_state <= lpif_pkg::SYNC_ONLINE;
        end
      endcase
    end
  end

  assign rx_online_delay = (rx_state == lpif_pkg::SYNC_ONLINE);

endmodule

// ==== rtl/lpif_flit_pack.sv ====
/* Flit packer, registers upstream user fields into a flit
   and unpacks pushed flits onto the downstream port */

`timescale 1ns/100ps

module lpif_flit_pack (
  input  logic                clk_wr,
  input  logic                rst,

  // Upstream user port
  input  logic [3:0]          ustrm_state,
  input  logic [1:0]          ustrm_protid,
  input  logic [127:0]        ustrm_data,
  input  logic                ustrm_dvalid,
  input  logic [3:0]          ustrm_crc,
  input  logic                ustrm_crc_valid,
  input  logic                ustrm_valid,

  // Received flit from the lanes
  input  lpif_pkg::lpif_flit_t rx_flit,
  input  logic                rx_flit_push,

  // Flit toward the lanes
  output lpif_pkg::lpif_flit_t tx_flit,

  // Downstream user port
  output logic [3:0]          dstrm_state,
  output logic [1:0]          dstrm_protid,
  output logic [127:0]        dstrm_data,
  output logic                dstrm_dvalid,
  output logic [3:0]          dstrm_crc,
  output logic                dstrm_crc_valid,
  output logic                dstrm_valid
);

  lpif_pkg::lpif_flit_t dstrm_q;

  ////////////////////////////////////////////////////////////
  // Upstream pack

  // One register stage, every cycle carries a word
  always_ff @(posedge clk_wr) begin
    tx_flit.state     <= ustrm_state;
    tx_flit.protid    <= ustrm_protid;
    tx_flit.data      <= ustrm_data;
    tx_flit.dvalid    <= ustrm_dvalid;
    tx_flit.crc       <= ustrm_crc;
    tx_flit.crc_valid <= ustrm_crc_valid;
    tx_flit.valid     <= ustrm_valid;
  end

  ////////////////////////////////////////////////////////////
  // Downstream unpack

  // Only pushed flits reach the user port
  // Idle cycles show all zero, no stale data
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      dstrm_q <= '0;
    end else if (rx_flit_push) begin
      dstrm_q <= rx_flit;
    end else begin
      dstrm_q <= '0;
    end
  end

  // Field split
  assign dstrm_state     = dstrm_q.state;
  assign dstrm_protid    = dstrm_q.protid;
  assign dstrm_data      = dstrm_q.data;
  assign dstrm_dvalid    = dstrm_q.dvalid;
  assign dstrm_crc       = dstrm_q.crc;
  assign dstrm_crc_valid = dstrm_q.crc_valid;
  assign dstrm_valid     = dstrm_q.valid;

endmodule

// ==== rtl/lane_concat.sv ====
/* Lane concatenation that spreads flits over four PHY lanes with strobe
   and marker, reassembles received lanes and keeps debug counters */

`timescale 1ns/100ps

module lane_concat (
  input  logic                 clk_wr,
  input  logic                 rst,

  // Transmit flit and auto-sync levels
  input  lpif_pkg::lpif_flit_t tx_flit,
  input  logic                 tx_online_delay,
  input  logic                 tx_strobe_en,
  input  logic                 rx_online_delay,

  // PHY interconnect
  output logic [39:0]          tx_phy0,
  output logic [39:0]          tx_phy1,
  output logic [39:0]          tx_phy2,
  output logic [39:0]          tx_phy3,
  input  logic [39:0]          rx_phy0,
  input  logic [39:0]          rx_phy1,
  input  logic [39:0]          rx_phy2,
  input  logic [39:0]          rx_phy3,

  // Reassembled flit
  output lpif_pkg::lpif_flit_t rx_flit,
  output logic                 rx_flit_push,

  // Debug status
  output logic [31:0]          rx_downstream_debug_status,
  output logic [31:0]          tx_upstream_debug_status
);

  localparam int PW      = lpif_pkg::LANE_PAYLOAD_W;
  localparam int PAD_W   = lpif_pkg::LANE_PAD_W;
  localparam int FLIT_W  = lpif_pkg::FLIT_W;
  localparam int CNT_W   = lpif_pkg::DBG_CNT_W;

  logic [PAD_W-1:0]            tx_pad;
  logic [PAD_W-1:0]            tx_gated;
  logic [PAD_W-1:0]            rx_pad;
  logic [lpif_pkg::LANE_W-1:0] tx_lane_q [lpif_pkg::NUM_LANES];
  logic [lpif_pkg::LANE_W-1:0] rx_lane   [lpif_pkg::NUM_LANES];
  logic [lpif_pkg::LANE_W-1:0] rx_lane_q [lpif_pkg::NUM_LANES];
  logic                        rx_push_q;
  logic [CNT_W-1:0]            rx_flit_cnt;
  logic [CNT_W-1:0]            rx_stb_err_cnt;
  logic [CNT_W-1:0]            tx_flit_cnt;

  // Saturating increment for the debug counters
  function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] cnt,
                                               input logic en);
    if (en && (cnt != '1)) begin
      return cnt + 1'b1;
    end
    return cnt;
  endfunction

  ////////////////////////////////////////////////////////////
  // Transmit

  // Lane 3 top bits padded with zero
  assign tx_pad   = {{(PAD_W - FLIT_W){1'b0}}, tx_flit};
  // Payload held off until online
  assign tx_gated = tx_pad & {PAD_W{tx_online_delay}};

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      for (int k = 0; k < lpif_pkg::NUM_LANES; k++) begin
        tx_lane_q[k] <= '0;
      end
    end else begin
      // Marker unused
      // Strobe follows auto-sync
      for (int k = 0; k < lpif_pkg::NUM_LANES; k++) begin
        tx_lane_q[k][lpif_pkg::LANE_MRK_BIT] <= 1'b0;
        tx_lane_q[k][PW:1]                   <= tx_gated[k*PW +: PW];
        tx_lane_q[k][lpif_pkg::LANE_STB_BIT] <= tx_strobe_en;
      end
    end
  end

  assign tx_phy0 = tx_lane_q[0];
  assign tx_phy1 = tx_lane_q[1];
  assign tx_phy2 = tx_lane_q[2];
  assign tx_phy3 = tx_lane_q[3];

  ////////////////////////////////////////////////////////////
  // Receive

  assign rx_lane[0] = rx_phy0;
  assign rx_lane[1] = rx_phy1;
  assign rx_lane[2] = rx_phy2;
  assign rx_lane[3] = rx_phy3;

  // Received lane words
  always_ff @(posedge clk_wr) begin
    for (int k = 0; k < lpif_pkg::NUM_LANES; k++) begin
      rx_lane_q[k] <= rx_lane[k];
    end
  end

  // Push lines up with the registered lanes
  // Lane 0 strobe alone qualifies the word
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_push_q <= 1'b0;
    end else begin
      rx_push_q <= rx_online_delay && rx_phy0[lpif_pkg::LANE_STB_BIT];
    end
  end

  // Strip strobe and marker to rebuild the flit
  always_comb begin
    for (int k = 0; k < lpif_pkg::NUM_LANES; k++) begin
      rx_pad[k*PW +: PW] = rx_lane_q[k][PW:1];
    end
  end

  assign rx_flit      = rx_pad[FLIT_W-1:0];
  assign rx_flit_push = rx_push_q;

  ////////////////////////////////////////////////////////////
  // Debug counters

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_flit_cnt    <= '0;
      rx_stb_err_cnt <= '0;
      tx_flit_cnt    <= '0;
    end else begin
      // Pushed flits with valid set
      rx_flit_cnt    <= sat_inc(rx_flit_cnt, rx_push_q && rx_flit.valid);
      // Online cycle but lane 0 strobe missing
      rx_stb_err_cnt <= sat_inc(rx_stb_err_cnt,
                                rx_online_delay && !rx_phy0[lpif_pkg::LANE_STB_BIT]);
      // Valid flits sent with payload open
      tx_flit_cnt    <= sat_inc(tx_flit_cnt, tx_online_delay && tx_flit.valid);
    end
  end

  assign rx_downstream_debug_status = {rx_flit_cnt, rx_stb_err_cnt};
  assign tx_upstream_debug_status   = {tx_flit_cnt, {CNT_W{1'b0}}};

endmodule

// ==== rtl/lpif_link_slave_top.sv ====
/* LPIF link slave top, auto-sync, flit packer and four-lane
   concatenation over a 40-bit-per-channel PHY interconnect */

`timescale 1ns/100ps

module lpif_link_slave_top #(
  parameter int DELAY_W = 16
) (
  input  logic               clk_wr,
  input  logic               rst,

  // Online levels
  input  logic               tx_online,
  input  logic               rx_online,

  // Auto-sync delays
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,
  input  logic [DELAY_W-1:0] delay_z_value,

  // Upstream user port
  input  logic [3:0]         ustrm_state,
  input  logic [1:0]         ustrm_protid,
  input  logic [127:0]       ustrm_data,
  input  logic               ustrm_dvalid,
  input  logic [3:0]         ustrm_crc,
  input  logic               ustrm_crc_valid,
  input  logic               ustrm_valid,

  // Downstream user port
  output logic [3:0]         dstrm_state,
  output logic [1:0]         dstrm_protid,
  output logic [127:0]       dstrm_data,
  output logic               dstrm_dvalid,
  output logic [3:0]         dstrm_crc,
  output logic               dstrm_crc_valid,
  output logic               dstrm_valid,

  // PHY interconnect
  output logic [39:0]        tx_phy0,
  output logic [39:0]        tx_phy1,
  output logic [39:0]        tx_phy2,
  output logic [39:0]        tx_phy3,
  input  logic [39:0]        rx_phy0,
  input  logic [39:0]        rx_phy1,
  input  logic [39:0]        rx_phy2,
  input  logic [39:0]        rx_phy3,

  // Debug status
  output logic [31:0]        rx_downstream_debug_status,
  output logic [31:0]        tx_upstream_debug_status
);

  ////////////////////////////////////////////////////////////
  // Internal wires

  logic                 tx_online_delay;
  logic                 tx_strobe_en;
  logic                 rx_online_delay;
  lpif_pkg::lpif_flit_t tx_flit;
  lpif_pkg::lpif_flit_t rx_flit;
  logic                 rx_flit_push;

  ////////////////////////////////////////////////////////////
  // Auto-sync

  link_auto_sync #(
    .DELAY_W (DELAY_W)
  ) u_auto_sync (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .tx_strobe_en    (tx_strobe_en),
    .rx_online_delay (rx_online_delay)
  );

  ////////////////////////////////////////////////////////////
  // User side

  lpif_flit_pack u_flit_pack (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .rx_flit         (rx_flit),
    .rx_flit_push    (rx_flit_push),
    .tx_flit         (tx_flit),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

  ////////////////////////////////////////////////////////////
  // PHY side

  lane_concat u_lane_concat (
    .clk_wr                     (clk_wr),
    .rst                        (rst),
    .tx_flit                    (tx_flit),
    .tx_online_delay            (tx_online_delay),
    .tx_strobe_en               (tx_strobe_en),
    .rx_online_delay            (rx_online_delay),
    .tx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .tx_phy2                    (tx_phy2),
    .tx_phy3                    (tx_phy3),
    .rx_phy0                    (rx_phy0),
    .rx_phy1                    (rx_phy1),
    .rx_phy2                    (rx_phy2),
    .rx_phy3                    (rx_phy3),
    .rx_flit                    (rx_flit),
    .rx_flit_push               (rx_flit_push),
    .rx_downstream_debug_status (rx_downstream_debug_status),
    .tx_upstream_debug_status   (tx_upstream_debug_status)
  );

endmodule

// ==== verif/lpif_link_slave_tb.sv ====
/* LPIF link slave testbench, external PHY loopback with a strobe mask,
   table-driven flits checked on the downstream port */

`timescale 1ns/100ps

module lpif_link_slave_tb;

  localparam int DELAY_W = 16;
  localparam int TBL_LEN = 32;
  // Auto-sync delays
  localparam int DX      = 2;
  localparam int DY      = 3;
  localparam int DZ      = 4;
  // Watchdog budget, 8 ns per cycle
  localparam int WD_NS   = (TBL_LEN + DX + DY + DZ + 50) * 8;

  // One table row: driven flit, strobe drop, expected dstrm
  typedef struct packed {
    lpif_pkg::lpif_flit_t flit;
    logic                 drop;
    lpif_pkg::lpif_flit_t want;
  } stim_t;

  logic                 clk_wr = 1'b0;
  logic                 rst;
  logic                 tx_online;
  logic                 rx_online;
  logic [DELAY_W-1:0]   delay_x_value;
  logic [DELAY_W-1:0]   delay_y_value;
  logic [DELAY_W-1:0]   delay_z_value;
  logic [3:0]           ustrm_state;
  logic [1:0]           ustrm_protid;
  logic [127:0]         ustrm_data;
  logic                 ustrm_dvalid;
  logic [3:0]           ustrm_crc;
  logic                 ustrm_crc_valid;
  logic                 ustrm_valid;
  logic [3:0]           dstrm_state;
  logic [1:0]           dstrm_protid;
  logic [127:0]         dstrm_data;
  logic                 dstrm_dvalid;
  logic [3:0]           dstrm_crc;
  logic                 dstrm_crc_valid;
  logic                 dstrm_valid;
  logic [39:0]          tx_phy0;
  logic [39:0]          tx_phy1;
  logic [39:0]          tx_phy2;
  logic [39:0]          tx_phy3;
  logic [39:0]          rx_phy0;
  logic [39:0]          rx_phy1;
  logic [39:0]          rx_phy2;
  logic [39:0]          rx_phy3;
  logic [31:0]          rx_downstream_debug_status;
  logic [31:0]          tx_upstream_debug_status;

  // Loopback mask, clears lane 0 strobe
  logic                 drop_stb;
  logic [39:0]          tx_lane [4];
  stim_t                stim_tbl [TBL_LEN];
  lpif_pkg::lpif_flit_t exp_q [$];
  lpif_pkg::lpif_flit_t idle_pat;
  lpif_pkg::lpif_flit_t exp_flit;
  int                   n_valid;
  int                   n_kept;
  int                   n_drop;

  always #4 clk_wr = ~clk_wr;

  lpif_link_slave_top #(
    .DELAY_W (DELAY_W)
  ) uut (
    .clk_wr                     (clk_wr),
    .rst                        (rst),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .delay_z_value              (delay_z_value),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .tx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .tx_phy2                    (tx_phy2),
    .tx_phy3                    (tx_phy3),
    .rx_phy0                    (rx_phy0),
    .rx_phy1                    (rx_phy1),
    .rx_phy2                    (rx_phy2),
    .rx_phy3                    (rx_phy3),
    .rx_downstream_debug_status (rx_downstream_debug_status),
    .tx_upstream_debug_status   (tx_upstream_debug_status)
  );

  // External loopback, only lane 0 strobe can be masked
  assign rx_phy0 = {tx_phy0[39:1], tx_phy0[0] & ~drop_stb};
  assign rx_phy1 = tx_phy1;
  assign rx_phy2 = tx_phy2;
  assign rx_phy3 = tx_phy3;

  assign tx_lane[0] = tx_phy0;
  assign tx_lane[1] = tx_phy1;
  assign tx_lane[2] = tx_phy2;
  assign tx_lane[3] = tx_phy3;

  ////////////////////////////////////////////////////////////
  // Helpers

  task automatic check_val(input string name, input logic [159:0] act,
                           input logic [159:0] want);
    if (act !== want) begin
      $display("ERR t=%0t %s act=%0h exp=%0h", $time, name, act, want);
      $display("*** TEST FAILED ***");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  // Lane k: marker 0, flit bits from 38*k in 38..1, strobe at bit 0
  function automatic logic [39:0] lane_word(input lpif_pkg::lpif_flit_t f, input int k,
                                            input logic stb, input logic online);
    logic [151:0] pad;
    logic [37:0]  pay;
    pad = 152'(f);
    pay = online ? pad[k*38 +: 38] : 38'b0;
    return {1'b0, pay, stb};
  endfunction

  task automatic check_lanes(input lpif_pkg::lpif_flit_t f, input logic stb,
                             input logic online);
    for (int k = 0; k < 4; k++) begin
      check_val($sformatf("tx_phy%0d", k), 160'(tx_lane[k]),
                160'(lane_word(f, k, stb, online)));
    end
  endtask

  task automatic compare_dstrm(input lpif_pkg::lpif_flit_t want);
    check_val("dstrm_state", 160'(dstrm_state), 160'(want.state));
    check_val("dstrm_protid", 160'(dstrm_protid), 160'(want.protid));
    check_val("dstrm_data", 160'(dstrm_data), 160'(want.data));
    check_val("dstrm_dvalid", 160'(dstrm_dvalid), 160'(want.dvalid));
    check_val("dstrm_crc", 160'(dstrm_crc), 160'(want.crc));
    check_val("dstrm_crc_valid", 160'(dstrm_crc_valid), 160'(want.crc_valid));
    check_val("dstrm_valid", 160'(dstrm_valid), 160'(want.valid));
  endtask

  task automatic drive_flit(input lpif_pkg::lpif_flit_t f);
    ustrm_state     <= f.state;
    ustrm_protid    <= f.protid;
    ustrm_data      <= f.data;
    ustrm_dvalid    <= f.dvalid;
    ustrm_crc       <= f.crc;
    ustrm_crc_valid <= f.crc_valid;
    ustrm_valid     <= f.valid;
  endtask

  ////////////////////////////////////////////////////////////
  // Watchdog

  initial begin
    #(WD_NS);
    $display("*** TEST FAILED ***");
    $fatal(1, "Timeout, the test did not finish in %0d ns", WD_NS);
  end

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    logic [31:0]          r;
    lpif_pkg::lpif_flit_t f;
    rst             = 1'b1;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    delay_x_value   = DELAY_W'(DX);
    delay_y_value   = DELAY_W'(DY);
    delay_z_value   = DELAY_W'(DZ);
    ustrm_state     = '0;
    ustrm_protid    = '0;
    ustrm_data      = '0;
    ustrm_dvalid    = 1'b0;
    ustrm_crc       = '0;
    ustrm_crc_valid = 1'b0;
    ustrm_valid     = 1'b0;
    drop_stb        = 1'b0;
    n_valid         = 0;
    n_kept          = 0;
    n_drop          = 0;
    void'($urandom(32'h89c5_9efe));

    // Idle pattern, valid clear so no counter moves
    idle_pat           = '0;
    idle_pat.state     = 4'h5;
    idle_pat.protid    = 2'h2;
    idle_pat.data      = {4{32'ha5c3_1e87}};
    idle_pat.dvalid    = 1'b1;
    idle_pat.crc       = 4'h9;
    idle_pat.crc_valid = 1'b1;

    // Table fill, random fields
    for (int i = 0; i < TBL_LEN; i++) begin
      r              = $urandom;
      f.state        = r[3:0];
      f.protid       = r[5:4];
      f.dvalid       = r[6];
      f.crc          = r[11:8];
      f.crc_valid    = r[12];
      f.data         = {$urandom, $urandom, $urandom, $urandom};
      // Some flits with valid clear
      f.valid        = (i % 5 != 3);
      stim_tbl[i].flit = f;
      // Word 13 is a dropped flit with valid clear
      stim_tbl[i].drop = (i == 9) || (i == 10) || (i == 13);
      stim_tbl[i].want = stim_tbl[i].drop ? '0 : f;
      if (f.valid) begin
        n_valid++;
      end
      if (f.valid && !stim_tbl[i].drop) begin
        n_kept++;
      end
      if (stim_tbl[i].drop) begin
        n_drop++;
      end
    end

    // Reset
    repeat (3) @(posedge clk_wr);
    rst <= 1'b0;
    @(negedge clk_wr);
    check_lanes('0, 1'b0, 1'b0);
    compare_dstrm('0);
    check_val("rx_downstream_debug_status", 160'(rx_downstream_debug_status), 160'(0));
    check_val("tx_upstream_debug_status", 160'(tx_upstream_debug_status), 160'(0));

    @(posedge clk_wr);
    drive_flit(idle_pat);
    @(posedge clk_wr);
    tx_online <= 1'b1;

    // Tx bring-up with rx held offline
    // strobe after delay_y plus the lane register, payload after delay_z too
    for (int k = 1; k <= DY + DZ + 8; k++) begin
      @(posedge clk_wr);
      @(negedge clk_wr);
      check_lanes(idle_pat, (k >= DY + 2), (k >= DY + DZ + 2));
      compare_dstrm('0);
    end

    // Rx bring-up
    @(posedge clk_wr);
    rx_online <= 1'b1;
    repeat (DX + 2) @(posedge clk_wr);
    @(negedge clk_wr);
    check_val("rx_stb_err_cnt", 160'(rx_downstream_debug_status[15:0]), 160'(0));

    ////////////////////////////////////////////////////////////
    // Table loop, 4-cycle loopback latency

    for (int c = 0; c < TBL_LEN + 4; c++) begin
      @(posedge clk_wr);
      if (c < TBL_LEN) begin
        drive_flit(stim_tbl[c].flit);
        exp_q.push_back(stim_tbl[c].want);
      end else begin
        drive_flit('0);
      end
      // Word c-2 sits on tx_phy this cycle
      if (c >= 2 && c - 2 < TBL_LEN) begin
        drop_stb <= stim_tbl[c-2].drop;
      end else begin
        drop_stb <= 1'b0;
      end
      @(negedge clk_wr);
      if (c >= 4) begin
        exp_flit = exp_q.pop_front();
        compare_dstrm(exp_flit);
      end
    end

    // Debug counters after the drain
    @(posedge clk_wr);
    @(negedge clk_wr);
    check_val("tx_dbg_flits", 160'(tx_upstream_debug_status[31:16]), 160'(n_valid));
    check_val("tx_dbg_low", 160'(tx_upstream_debug_status[15:0]), 160'(0));
    check_val("rx_dbg_flits", 160'(rx_downstream_debug_status[31:16]), 160'(n_kept));
    check_val("rx_stb_err_cnt", 160'(rx_downstream_debug_status[15:0]), 160'(n_drop));

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== list.f ====
rtl/lpif_pkg.sv
rtl/link_auto_sync.sv
rtl/lpif_flit_pack.sv
rtl/lane_concat.sv
rtl/lpif_link_slave_top.sv
verif/lpif_link_slave_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module lpif_link_slave_tb -f list.f --Mdir obj_dir
	./obj_dir/Vlpif_link_slave_tb

clean:
	rm -rf obj_dir
